// ==== Makefile ====
# Verilator build and run for the queue page manager

SIM      = verilator
TOP      = queue_mmu_tb
FILELIST = queue_mmu.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit status of the binary
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/page_allocator.sv ====
//////////////////////////////////////////////////
// Streams stay idle for NUM_PAGES cycles after reset while the ring fills
// Releasing a page that is already free is not detected beyond a full ring
//////////////////////////////////////////////////

`timescale 1ns/1ns

module page_allocator (
    input  logic                malloc,
    input  logic                reset,
    // Alloc stream towards the linker
    output logic                alloc_valid,
    input  logic                alloc_ready,
    output queue_pkg::page_t    alloc_page,
    // Release stream from outside
    input  logic                rel_valid,
    input  queue_pkg::page_t    rel_page,
    output logic                rel_ready,
    output queue_pkg::count_t   free_pages
);

    import queue_pkg::*;

    //////////////////////////////////////////////////
    // Types and signals
    //////////////////////////////////////////////////

    typedef enum logic {
        INIT,
        ACTIVE
    } alloc_state_t;

    alloc_state_t state;

    // Ring of free page numbers
    page_t ring [NUM_PAGES];

    // Pointers carry a wrap bit above the index
    logic [PAGE_W:0] rd_ptr;
    logic [PAGE_W:0] wr_ptr;
    count_t          fill;

    logic            alloc_fire;
    logic            rel_fire;

    // Ring write port, shared by init and release
    logic            ring_we;
    page_t           ring_waddr;
    page_t           ring_wdata;

    //////////////////////////////////////////////////
    // Handshakes and status
    //////////////////////////////////////////////////

    // Wrap bit makes the full case 64 and the empty case 0
    assign fill = wr_ptr - rd_ptr;

    // Count held at zero until the ring is built
    assign free_pages  = (state == ACTIVE) ? fill : '0;

    assign alloc_valid = (state == ACTIVE) && (fill != '0);
    assign rel_ready   = (state == ACTIVE);

    // Head of the ring, read combinationally
    assign alloc_page  = ring[rd_ptr[PAGE_W-1:0]];

    assign alloc_fire  = alloc_valid && alloc_ready;
    assign rel_fire    = rel_valid && rel_ready;

    // Init writes page n at slot n, release appends at the tail
    assign ring_we    = (state == INIT) || rel_fire;
    assign ring_waddr = wr_ptr[PAGE_W-1:0];
    assign ring_wdata = (state == INIT) ? wr_ptr[PAGE_W-1:0] : rel_page;

    //////////////////////////////////////////////////
    // Pointer and state control
    //////////////////////////////////////////////////

    always_ff @(posedge malloc) begin
        if (reset) begin
            state  <= INIT;
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            case (state)
                INIT: begin
                    // One slot per cycle, the write pointer doubles as counter
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_ptr[PAGE_W-1:0] == PAGE_W'(NUM_PAGES - 1)) begin
                        state <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    // Alloc and release may both fire in one cycle
                    if (alloc_fire) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                    if (rel_fire) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    // Ring storage
    always_ff @(posedge malloc) begin
        if (ring_we) begin
            ring[ring_waddr] <= ring_wdata;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // With every page free, any release would duplicate a page
    a_no_release_when_full : assert property (
        @(posedge malloc) disable iff (reset)
        rel_fire |-> (fill != COUNT_W'(NUM_PAGES))
    );

endmodule

// ==== hdl/queue_linker.sv ====
//////////////////////////////////////////////////
// A pending dequeue stalls every enqueue in that cycle
// Head of an empty queue holds a stale page and must not be used
//////////////////////////////////////////////////

`timescale 1ns/1ns

module queue_linker (
    input  logic                                        malloc,
    input  logic                                        reset,
    // Enqueue stream
    input  logic                                        enq_valid,
    input  queue_pkg::qid_t                             enq_qid,
    output logic                                        enq_ready,
    output queue_pkg::page_t                            enq_page,
    // Dequeue stream
    input  logic                                        deq_valid,
    input  queue_pkg::qid_t                             deq_qid,
    output logic                                        deq_ready,
    output queue_pkg::page_t                            deq_page,
    // Alloc stream from the free list
    input  logic                                        alloc_valid,
    input  queue_pkg::page_t                            alloc_page,
    output logic                                        alloc_ready,
    // Per-queue enable mask and occupancy
    input  logic [queue_pkg::NUM_QUEUES-1:0]            enable,
    output queue_pkg::count_t [queue_pkg::NUM_QUEUES-1:0] depth
);

    import queue_pkg::*;

    //////////////////////////////////////////////////
    // Signals
    //////////////////////////////////////////////////

    // Per-queue chain state
    page_t                     head_q [NUM_QUEUES];
    page_t                     tail_q [NUM_QUEUES];
    count_t [NUM_QUEUES-1:0]   depth_q;

    // Successor of each page within its chain
    page_t                     next_tab [NUM_PAGES];

    logic                      enq_fire;
    logic                      deq_fire;
    logic                      enq_empty;

    // Wide enough for four full counts
    logic [COUNT_W+QID_W-1:0]  depth_sum;

    //////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////

    // Dequeue wins, enqueue also needs a free page and an enabled queue
    assign enq_ready   = alloc_valid && enable[enq_qid] && !deq_valid;
    assign enq_fire    = enq_valid && enq_ready;

    // Page is taken from the free list only on an enqueue transfer
    assign alloc_ready = enq_fire;
    assign enq_page    = alloc_page;

    assign deq_ready   = (depth_q[deq_qid] != '0);
    assign deq_fire    = deq_valid && deq_ready;
    assign deq_page    = head_q[deq_qid];

    assign enq_empty   = (depth_q[enq_qid] == '0);

    assign depth       = depth_q;

    //////////////////////////////////////////////////
    // Queue state
    //////////////////////////////////////////////////

    always_ff @(posedge malloc) begin
        if (reset) begin
            depth_q <= '0;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                head_q[q] <= '0;
                tail_q[q] <= '0;
            end
        end else begin
            // Enqueue and dequeue never fire together
            if (enq_fire) begin
                // Empty queue starts a new chain at the granted page
                if (enq_empty) begin
                    head_q[enq_qid] <= alloc_page;
                end
                tail_q[enq_qid]  <= alloc_page;
                depth_q[enq_qid] <= depth_q[enq_qid] + 1'b1;
            end else if (deq_fire) begin
                // Step the head along the chain
                head_q[deq_qid]  <= next_tab[head_q[deq_qid]];
                depth_q[deq_qid] <= depth_q[deq_qid] - 1'b1;
            end
        end
    end

    // Link table, written only when appending behind an existing tail
    always_ff @(posedge malloc) begin
        if (enq_fire && !enq_empty) begin
            next_tab[tail_q[enq_qid]] <= alloc_page;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    always_comb begin
        depth_sum = '0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            depth_sum = depth_sum + (COUNT_W+QID_W)'(depth_q[q]);
        end
    end

    // Last page handed out must be the tail, or the chain underflows to a stale head
    a_last_page_is_tail : assert property (
        @(posedge malloc) disable iff (reset)
        (deq_fire && (depth_q[deq_qid] == COUNT_W'(1)))
        |-> (head_q[deq_qid] == tail_q[deq_qid])
    );

    // Pages in all queues together cannot exceed the buffer
    a_depth_sum_bound : assert property (
        @(posedge malloc) disable iff (reset)
        depth_sum <= (COUNT_W+QID_W)'(NUM_PAGES)
    );

endmodule

// ==== hdl/queue_mmu.sv ====
//////////////////////////////////////////////////
// Streams and APB are idle for NUM_PAGES cycles after reset
//////////////////////////////////////////////////

`timescale 1ns/1ns

module queue_mmu (
    input  logic                      malloc,
    input  logic                      reset,
    // Enqueue stream
    input  logic                      enq_valid,
    input  queue_pkg::qid_t           enq_qid,
    output logic                      enq_ready,
    output queue_pkg::page_t          enq_page,
    // Dequeue stream
    input  logic                      deq_valid,
    input  queue_pkg::qid_t           deq_qid,
    output logic                      deq_ready,
    output queue_pkg::page_t          deq_page,
    // Release stream
    input  logic                      rel_valid,
    input  queue_pkg::page_t          rel_page,
    output logic                      rel_ready,
    // Register bus
    input  queue_pkg::apb_req_t       apb_req,
    output queue_pkg::apb_rsp_t       apb_rsp
);

    import queue_pkg::*;

    // Free list to linker
    logic                      alloc_valid;
    logic                      alloc_ready;
    page_t                     alloc_page;

    // Occupancy and control
    count_t                    free_pages;
    count_t [NUM_QUEUES-1:0]   depth;
    logic [NUM_QUEUES-1:0]     enable;
    queue_status_t             status;

    assign status.free_pages = free_pages;
    assign status.depth      = depth;

    page_allocator u_page_allocator (
        .malloc      (malloc),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_page  (alloc_page),
        .rel_valid   (rel_valid),
        .rel_page    (rel_page),
        .rel_ready   (rel_ready),
        .free_pages  (free_pages)
    );

    queue_linker u_queue_linker (
        .malloc      (malloc),
        .reset       (reset),
        .enq_valid   (enq_valid),
        .enq_qid     (enq_qid),
        .enq_ready   (enq_ready),
        .enq_page    (enq_page),
        .deq_valid   (deq_valid),
        .deq_qid     (deq_qid),
        .deq_ready   (deq_ready),
        .deq_page    (deq_page),
        .alloc_valid (alloc_valid),
        .alloc_page  (alloc_page),
        .alloc_ready (alloc_ready),
        .enable      (enable),
        .depth       (depth)
    );

    queue_regs u_queue_regs (
        .malloc  (malloc),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .status  (status),
        .enable  (enable)
    );

endmodule

// ==== hdl/queue_pkg.sv ====
//////////////////////////////////////////////////
// Sizes fixed at 64 pages and 4 queues, counts reach NUM_PAGES
// APB map is byte addressed with 32-bit registers
//////////////////////////////////////////////////

package queue_pkg;

    //////////////////////////////////////////////////
    // Buffer and queue sizes
    //////////////////////////////////////////////////

    localparam int NUM_PAGES  = 64;
    localparam int PAGE_W     = $clog2(NUM_PAGES);
    // One extra bit so a full ring reads 64
    localparam int COUNT_W    = PAGE_W + 1;
    localparam int NUM_QUEUES = 4;
    localparam int QID_W      = $clog2(NUM_QUEUES);

    //////////////////////////////////////////////////
    // APB address map
    //////////////////////////////////////////////////

    localparam logic [7:0] ADDR_FREE       = 8'h00;
    // Depth of queue i sits at base plus 4 times i
    localparam logic [7:0] ADDR_DEPTH_BASE = 8'h04;
    localparam logic [7:0] ADDR_ENABLE     = 8'h20;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [PAGE_W-1:0]  page_t;
    typedef logic [QID_W-1:0]   qid_t;
    typedef logic [COUNT_W-1:0] count_t;

    // Requester side of the APB bus
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Completer side of the APB bus
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Occupancy snapshot for the register block
    typedef struct packed {
        count_t                    free_pages;
        count_t [NUM_QUEUES-1:0]   depth;
    } queue_status_t;

endpackage

// ==== hdl/queue_regs.sv ====
//////////////////////////////////////////////////
// Zero wait state APB, only the enable mask is writable
// Upper bits of the enable write data are ignored
//////////////////////////////////////////////////

`timescale 1ns/1ns

module queue_regs (
    input  logic                               malloc,
    input  logic                               reset,
    input  queue_pkg::apb_req_t                apb_req,
    output queue_pkg::apb_rsp_t                apb_rsp,
    input  queue_pkg::queue_status_t           status,
    output logic [queue_pkg::NUM_QUEUES-1:0]   enable
);

    import queue_pkg::*;

    //////////////////////////////////////////////////
    // Signals
    //////////////////////////////////////////////////

    logic                  access;
    logic                  hit_free;
    logic                  hit_depth;
    logic                  hit_enable;
    logic                  mapped;
    logic [31:0]           rd_data;
    logic [NUM_QUEUES-1:0] enable_q;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    // Access phase of a transfer
    assign access     = apb_req.psel && apb_req.penable;

    assign hit_free   = (apb_req.paddr == ADDR_FREE);
    assign hit_enable = (apb_req.paddr == ADDR_ENABLE);
    assign mapped     = hit_free || hit_depth || hit_enable;

    always_comb begin
        hit_depth = 1'b0;
        rd_data   = '0;
        if (hit_free) begin
            rd_data = 32'(status.free_pages);
        end
        if (hit_enable) begin
            rd_data = 32'(enable_q);
        end
        // Depth registers every 4 bytes
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (apb_req.paddr == 8'(ADDR_DEPTH_BASE + 4 * q)) begin
                hit_depth = 1'b1;
                rd_data   = 32'(status.depth[q]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    assign apb_rsp.pready  = access;
    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
    // Unmapped address, or a write to a status register
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && !hit_enable));

    //////////////////////////////////////////////////
    // Enable mask
    //////////////////////////////////////////////////

    always_ff @(posedge malloc) begin
        if (reset) begin
            enable_q <= '1;
        end else if (access && apb_req.pwrite && hit_enable) begin
            enable_q <= apb_req.pwdata[NUM_QUEUES-1:0];
        end
    end

    assign enable = enable_q;

    // Requester must not enter access phase without a select
    a_penable_needs_psel : assert property (
        @(posedge malloc) disable iff (reset)
        apb_req.penable |-> apb_req.psel
    );

endmodule

// ==== queue_mmu.f ====
hdl/queue_pkg.sv
hdl/page_allocator.sv
hdl/queue_linker.sv
hdl/queue_regs.sv
hdl/queue_mmu.sv
tests/queue_mmu_tb.sv

// ==== tests/queue_mmu_tb.sv ====
//////////////////////////////////////////////////
// Checks are concurrent assertions against a model of free list and queues
// Inputs change on the falling edge, the model follows each transfer there
//////////////////////////////////////////////////

`timescale 1ns/1ns

module queue_mmu_tb;

    import queue_pkg::*;

    localparam int CLK_PERIOD   = 100;
    // Init, random traffic, fill, drain, refill and APB phases with margin
    localparam int WATCHDOG_CYC = 2000;

    logic                  malloc = 1'b0;
    logic                  reset;
    logic                  enq_valid;
    qid_t                  enq_qid;
    logic                  enq_ready;
    page_t                 enq_page;
    logic                  deq_valid;
    qid_t                  deq_qid;
    logic                  deq_ready;
    page_t                 deq_page;
    logic                  rel_valid;
    page_t                 rel_page;
    logic                  rel_ready;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;

    // Transfers seen on the last rising edge
    logic                  rst_seen  = 1'b1;
    logic                  enq_hit   = 1'b0;
    logic                  deq_hit   = 1'b0;
    logic                  rel_hit   = 1'b0;
    logic                  enable_wr = 1'b0;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    page_t                 free_list [$];
    page_t                 qlist [NUM_QUEUES][$];
    // Dequeued pages waiting to go back
    page_t                 to_release [$];
    int                    exp_free = 0;
    page_t                 exp_alloc = '0;
    int                    exp_depth [NUM_QUEUES];
    page_t                 exp_head [NUM_QUEUES];
    logic [NUM_QUEUES-1:0] exp_enable = '1;
    bit                    model_active = 1'b0;
    int                    init_cnt = 0;
    int                    errors = 0;
    int unsigned           rng_state = 1701;
    logic [31:0]           exp_rdata;
    logic                  exp_err;

    always #(CLK_PERIOD / 2) malloc = ~malloc;

    queue_mmu u_queue_mmu (.*);

    always @(posedge malloc) begin
        rst_seen  <= reset;
        enq_hit   <= enq_valid && enq_ready;
        deq_hit   <= deq_valid && deq_ready;
        rel_hit   <= rel_valid && rel_ready;
        enable_wr <= apb_req.psel && apb_req.penable && apb_req.pwrite
                     && (apb_req.paddr == ADDR_ENABLE);
    end

    // Expected APB response from the register map
    always_comb begin
        exp_err   = 1'b1;
        exp_rdata = '0;
        if (apb_req.paddr == ADDR_FREE) begin
            exp_err   = apb_req.pwrite;
            exp_rdata = 32'(exp_free);
        end else if (apb_req.paddr == ADDR_ENABLE) begin
            exp_err   = 1'b0;
            exp_rdata = 32'(exp_enable);
        end
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (apb_req.paddr == 8'(ADDR_DEPTH_BASE + 4 * q)) begin
                exp_err   = apb_req.pwrite;
                exp_rdata = 32'(exp_depth[q]);
            end
        end
    end

    function automatic void log_mismatch(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endfunction

    function automatic logic [15:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];
    endfunction

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////

    a_grant_order : assert property (@(posedge malloc) disable iff (reset)
        (enq_valid && enq_ready) |-> (enq_page == exp_alloc))
        else log_mismatch("enqueue granted a page out of free-list order");
    // Needs a free page and an enabled queue, and yields to a dequeue
    a_enq_ready : assert property (@(posedge malloc) disable iff (reset)
        enq_valid |-> (enq_ready == (exp_free != 0 && exp_enable[enq_qid] && !deq_valid)))
        else log_mismatch("enq_ready differs from the model");
    a_deq_ready : assert property (@(posedge malloc) disable iff (reset)
        deq_valid |-> (deq_ready == (exp_depth[deq_qid] != 0)))
        else log_mismatch("deq_ready differs from the model depth");
    a_deq_order : assert property (@(posedge malloc) disable iff (reset)
        (deq_valid && deq_ready) |-> (deq_page == exp_head[deq_qid]))
        else log_mismatch("dequeued page is not the oldest of its queue");
    a_rel_ready : assert property (@(posedge malloc) disable iff (reset)
        rel_ready == model_active)
        else log_mismatch("rel_ready does not follow the end of init");
    a_apb_resp : assert property (@(posedge malloc) disable iff (reset)
        (apb_req.psel && apb_req.penable) |-> (apb_rsp.pready && (apb_rsp.pslverr == exp_err)))
        else log_mismatch("APB pready or pslverr wrong in access phase");
    a_apb_idle : assert property (@(posedge malloc) disable iff (reset)
        !(apb_req.psel && apb_req.penable) |-> !apb_rsp.pready)
        else log_mismatch("APB pready high outside an access phase");
    a_apb_read : assert property (@(posedge malloc) disable iff (reset)
        (apb_req.psel && apb_req.penable && !apb_req.pwrite && !exp_err)
        |-> (apb_rsp.prdata == exp_rdata))
        else log_mismatch("APB read data differs from the model");

    //////////////////////////////////////////////////
    // Model update and stimulus tasks
    //////////////////////////////////////////////////

    // Producers drop valid as soon as their transfer is seen
    task automatic update_model();
        page_t pg;
        if (rst_seen) begin
            free_list.delete();
            to_release.delete();
            for (int q = 0; q < NUM_QUEUES; q++) begin
                qlist[q].delete();
            end
            exp_enable   = '1;
            model_active = 1'b0;
            init_cnt     = 0;
        end else if (!model_active) begin
            init_cnt++;
            if (init_cnt == NUM_PAGES) begin
                model_active = 1'b1;
                for (int p = 0; p < NUM_PAGES; p++) begin
                    free_list.push_back(page_t'(p));
                end
            end
        end else begin
            if (enq_hit) begin
                pg = free_list.pop_front();
                qlist[enq_qid].push_back(pg);
                enq_valid = 1'b0;
            end
            if (deq_hit) begin
                pg = qlist[deq_qid].pop_front();
                to_release.push_back(pg);
                deq_valid = 1'b0;
            end
            if (rel_hit) begin
                free_list.push_back(rel_page);
                rel_valid = 1'b0;
            end
            if (enable_wr) begin
                exp_enable = apb_req.pwdata[NUM_QUEUES-1:0];
            end
        end
        exp_free  = free_list.size();
        exp_alloc = (exp_free > 0) ? free_list[0] : '0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            exp_depth[q] = qlist[q].size();
            exp_head[q]  = (exp_depth[q] > 0) ? qlist[q][0] : '0;
        end
    endtask

    task automatic step();
        @(negedge malloc);
        update_model();
    endtask

    task automatic enqueue(input qid_t q);
        enq_valid = 1'b1;
        enq_qid   = q;
        while (enq_valid) step();
    endtask

    task automatic dequeue(input qid_t q);
        deq_valid = 1'b1;
        deq_qid   = q;
        while (deq_valid) step();
    endtask

    task automatic release_page(input page_t p);
        rel_valid = 1'b1;
        rel_page  = p;
        while (rel_valid) step();
    endtask

    // Setup then access phase, zero wait states
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        step();
        apb_req.penable = 1'b1;
        step();
        apb_req = '0;
    endtask

    task automatic read_status();
        apb_access(1'b0, ADDR_FREE, '0);
        for (int q = 0; q < NUM_QUEUES; q++) begin
            apb_access(1'b0, 8'(ADDR_DEPTH_BASE + 4 * q), '0);
        end
        apb_access(1'b0, ADDR_ENABLE, '0);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [15:0] rnd;
        qid_t        q;
        reset     = 1'b1;
        enq_valid = 1'b0;
        enq_qid   = '0;
        deq_valid = 1'b0;
        deq_qid   = '0;
        rel_valid = 1'b0;
        rel_page  = '0;
        apb_req   = '0;
        repeat (4) step();
        reset = 1'b0;
        while (!model_active) step();

        // Full free list, mask all ones, first grant is page 0
        read_status();
        // Random mix, dequeue only from non-empty queues
        for (int i = 0; i < 80; i++) begin
            rnd = lcg_next();
            q   = rnd[1:0];
            if (rnd[9:8] != 2'b00 && exp_free > 0) begin
                enqueue(q);
            end else if (exp_depth[q] > 0) begin
                dequeue(q);
            end else if (exp_free > 0) begin
                enqueue(q);
            end
            if (i % 16 == 15) read_status();
        end
        for (int i = 0; i < NUM_QUEUES; i++) begin
            if (exp_depth[i] > 0) dequeue(qid_t'(i));
        end

        // Use up every page, then hold an enqueue against an empty free list
        while (exp_free > 0) begin
            rnd = lcg_next();
            enqueue(rnd[1:0]);
        end
        rnd       = lcg_next();
        enq_valid = 1'b1;
        enq_qid   = rnd[1:0];
        repeat (6) step();
        apb_access(1'b0, ADDR_FREE, '0);
        // One release lets the held enqueue through
        release_page(to_release.pop_front());
        while (enq_valid) step();

        // Drain, release one at a time, then reuse in release order
        for (int i = 0; i < NUM_QUEUES; i++) begin
            while (exp_depth[i] > 0) dequeue(qid_t'(i));
        end
        while (to_release.size() > 0) begin
            release_page(to_release.pop_front());
            apb_access(1'b0, ADDR_FREE, '0);
        end
        repeat (8) begin
            rnd = lcg_next();
            enqueue(rnd[1:0]);
        end
        read_status();

        // Queue 0 masked, the others keep moving
        apb_access(1'b1, ADDR_ENABLE, 32'h0000_000e);
        apb_access(1'b0, ADDR_ENABLE, '0);
        repeat (20) begin
            rnd = lcg_next();
            q   = (rnd[1:0] == 2'd0) ? 2'd1 : rnd[1:0];
            enqueue(q);
        end
        enq_valid = 1'b1;
        enq_qid   = '0;
        repeat (4) step();
        if (exp_depth[1] > 0) dequeue(2'd1);
        repeat (4) step();
        apb_access(1'b1, ADDR_ENABLE, 32'h0000_000f);
        while (enq_valid) step();

        // Bad accesses flag pslverr and leave every register alone
        apb_access(1'b0, 8'h14, '0);
        apb_access(1'b0, 8'h40, '0);
        apb_access(1'b1, ADDR_FREE, 32'h0000_003f);
        apb_access(1'b1, 8'h30, 32'h0000_0000);
        read_status();
        step();

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Watchdog timeout, the tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Simulation failed");
        $finish;
    end

endmodule
